//--- include/corr_patterns.svh
`ifndef CORR_PATTERNS_SVH
`define CORR_PATTERNS_SVH

// width of one coefficient word
`define CORR_PAT_W 8

// one word per correlator number, correlator 0 first
// bit k weights the sample that is k beats old
// a set bit adds the sample and a clear bit subtracts it
`define CORR_PATTERNS '{8'b1011_0001, 8'b0110_1010}

`endif

//--- hw/corr_pkg.sv
package corr_pkg;

  // sample and accumulator widths
  localparam int SAMPLE_W = 8;
  localparam int ACC_W    = 16;

  // defaults picked up by the top level
  localparam int DEF_LANES    = 4;
  localparam int DEF_CORR_LEN = 8;

  typedef logic signed [SAMPLE_W-1:0] sample_t;
  typedef logic signed [ACC_W-1:0]    acc_t;

  // lane counter, LANES-1 must fit
  typedef logic [$clog2(DEF_LANES)-1:0] lane_idx_t;

  // result source tag, correlator 0 or 1
  typedef logic corr_id_t;

  // correlator FSM
  typedef enum logic {
    COLLECT,
    HOLD
  } corr_state_t;

endpackage

//--- hw/bit_corr.sv
`timescale 1ns/1ps
`include "corr_patterns.svh"

module bit_corr #(
  parameter int LANES    = 4,
  parameter int CORR_LEN = 8,
  parameter int CORR_ID  = 0
) (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                lane_valid,
  output logic                                lane_ready,
  input  logic [LANES*corr_pkg::SAMPLE_W-1:0] lane_data,
  output logic                                res_valid,
  input  logic                                res_ready,
  output logic [LANES*corr_pkg::ACC_W-1:0]    res_data
);

  localparam logic [`CORR_PAT_W-1:0] PATTERN_SET [2] = `CORR_PATTERNS;

  corr_pkg::corr_state_t state;
  corr_pkg::lane_idx_t   lane;
  logic                  last_lane;
  logic                  step;
  corr_pkg::sample_t     sample;
  corr_pkg::acc_t        sample_ext;

  // adder chain, one adder per tap
  corr_pkg::acc_t chain_in  [CORR_LEN];
  corr_pkg::acc_t chain_out [CORR_LEN];

  // tap_mem[j][l] keeps adder j's last sum for lane l, feeds adder j+1
  corr_pkg::acc_t tap_mem [CORR_LEN-1][LANES];

  // finished sums of the current beat
  corr_pkg::acc_t slot [LANES];

  //////////////////////////////////////////////////////////////////////
  // lane sequencing
  //////////////////////////////////////////////////////////////////////

  assign last_lane = (lane == corr_pkg::lane_idx_t'(LANES - 1));

  // the beat itself is taken on the last lane
  assign lane_ready = (state == corr_pkg::COLLECT) && last_lane;
  assign step       = lane_valid && (state == corr_pkg::COLLECT);
  assign res_valid  = (state == corr_pkg::HOLD);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= corr_pkg::COLLECT;
      lane  <= '0;
    end else begin
      case (state)
        corr_pkg::COLLECT: begin
          if (step) begin
            // counter wraps back to lane 0 after the last lane
            lane <= lane + 1'b1;
            if (last_lane) begin
              state <= corr_pkg::HOLD;
            end
          end
        end
        corr_pkg::HOLD: begin
          if (res_ready) begin
            state <= corr_pkg::COLLECT;
          end
        end
        default: state <= corr_pkg::COLLECT;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // adders and tap memories
  //////////////////////////////////////////////////////////////////////

  assign sample     = lane_data[lane * corr_pkg::SAMPLE_W +: corr_pkg::SAMPLE_W];
  assign sample_ext = corr_pkg::acc_t'(sample);

  // adder k sees the newest sample, which is CORR_LEN-1-k beats old at the output
  for (genvar k = 0; k < CORR_LEN; k++) begin : g_tap
    if (k == 0) begin : g_first
      assign chain_in[k] = '0;
    end else begin : g_rest
      assign chain_in[k] = tap_mem[k-1][lane];
    end
    assign chain_out[k] = PATTERN_SET[CORR_ID][CORR_LEN-1-k] ?
                          chain_in[k] + sample_ext :
                          chain_in[k] - sample_ext;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int j = 0; j < CORR_LEN - 1; j++) begin
        for (int l = 0; l < LANES; l++) begin
          tap_mem[j][l] <= '0;
        end
      end
    end else if (step) begin
      for (int j = 0; j < CORR_LEN - 1; j++) begin
        tap_mem[j][lane] <= chain_out[j];
      end
    end
  end

  // last adder fills the output slot, frozen while in HOLD
  always_ff @(posedge clk) begin
    if (step) begin
      slot[lane] <= chain_out[CORR_LEN-1];
    end
  end

  for (genvar l = 0; l < LANES; l++) begin : g_pack
    assign res_data[l*corr_pkg::ACC_W +: corr_pkg::ACC_W] = slot[l];
  end

endmodule

//--- hw/result_arbiter.sv
`timescale 1ns/1ps

module result_arbiter #(
  parameter int LANES = 4
) (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic [1:0]                       req_valid,
  output logic [1:0]                       req_ready,
  input  logic [LANES*corr_pkg::ACC_W-1:0] req_data0,
  input  logic [LANES*corr_pkg::ACC_W-1:0] req_data1,
  output logic                             out_valid,
  input  logic                             out_ready,
  output logic [LANES*corr_pkg::ACC_W-1:0] out_data,
  output corr_pkg::corr_id_t               out_src
);

  // correlator with priority on the next tie
  corr_pkg::corr_id_t ptr;
  corr_pkg::corr_id_t pick;
  logic               load_ok;
  logic               grant;

  //////////////////////////////////////////////////////////////////////
  // grant selection
  //////////////////////////////////////////////////////////////////////

  // output register empty or draining this cycle
  assign load_ok = !out_valid || out_ready;
  assign grant   = load_ok && (|req_valid);

  // priority side if it asks, else the other one
  assign pick = req_valid[ptr] ? ptr : ~ptr;

  assign req_ready[0] = grant && (pick == 1'b0);
  assign req_ready[1] = grant && (pick == 1'b1);

  //////////////////////////////////////////////////////////////////////
  // output register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
      ptr       <= 1'b0;
    end else begin
      if (load_ok) begin
        out_valid <= |req_valid;
      end
      // pointer moves past the winner
      if (grant) begin
        ptr <= ~pick;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (grant) begin
      out_data <= pick ? req_data1 : req_data0;
      out_src  <= pick;
    end
  end

endmodule

//--- hw/corr_bank_top.sv
`timescale 1ns/1ps

module corr_bank_top #(
  parameter int LANES    = corr_pkg::DEF_LANES,
  parameter int CORR_LEN = corr_pkg::DEF_CORR_LEN
) (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                in_valid,
  output logic                                in_ready,
  input  logic [LANES*corr_pkg::SAMPLE_W-1:0] in_data,
  output logic                                out_valid,
  input  logic                                out_ready,
  output logic [LANES*corr_pkg::ACC_W-1:0]    out_data,
  output corr_pkg::corr_id_t                  out_src
);

  logic [1:0]                       lane_valid;
  logic [1:0]                       lane_ready;
  logic [1:0]                       res_valid;
  logic [1:0]                       res_ready;
  logic [LANES*corr_pkg::ACC_W-1:0] res_data0;
  logic [LANES*corr_pkg::ACC_W-1:0] res_data1;

  // beat goes in only when both sit on their last lane
  assign in_ready = &lane_ready;

  // earlier lanes run freely, the last lane waits for the peer
  assign lane_valid[0] = in_valid && (lane_ready[1] || !lane_ready[0]);
  assign lane_valid[1] = in_valid && (lane_ready[0] || !lane_ready[1]);

  bit_corr #(
    .LANES    (LANES),
    .CORR_LEN (CORR_LEN),
    .CORR_ID  (0)
  ) u_corr0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .lane_valid (lane_valid[0]),
    .lane_ready (lane_ready[0]),
    .lane_data  (in_data),
    .res_valid  (res_valid[0]),
    .res_ready  (res_ready[0]),
    .res_data   (res_data0)
  );

  bit_corr #(
    .LANES    (LANES),
    .CORR_LEN (CORR_LEN),
    .CORR_ID  (1)
  ) u_corr1 (
    .clk        (clk),
    .rst_n      (rst_n),
    .lane_valid (lane_valid[1]),
    .lane_ready (lane_ready[1]),
    .lane_data  (in_data),
    .res_valid  (res_valid[1]),
    .res_ready  (res_ready[1]),
    .res_data   (res_data1)
  );

  result_arbiter #(
    .LANES (LANES)
  ) u_arb (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_valid (res_valid),
    .req_ready (res_ready),
    .req_data0 (res_data0),
    .req_data1 (res_data1),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data),
    .out_src   (out_src)
  );

endmodule

//--- dv/corr_bank_assertions.sv
`timescale 1ns/1ps

module corr_bank_assertions #(
  parameter int LANES = 4
) (
  input logic                             clk,
  input logic                             rst_n,
  input logic                             in_ready,
  input logic                             out_valid,
  input logic                             out_ready,
  input logic [LANES*corr_pkg::ACC_W-1:0] out_data,
  input corr_pkg::corr_id_t               out_src,
  input logic [1:0]                       res_ready
);

  // failures seen so far, read by the testbench at the end
  int fail_count = 0;

  //////////////////////////////////////////////////////////////////////
  // reset and output protocol
  //////////////////////////////////////////////////////////////////////

  reset_idle: assert property (@(posedge clk) !rst_n |=> !out_valid && !in_ready)
    else begin
      $error("out_valid or in_ready high after a reset cycle");
      fail_count++;
    end

  // held result keeps its value until taken
  out_hold: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_src))
    else begin
      $error("output changed while out_ready was low");
      fail_count++;
    end

  // a granted correlator leaves HOLD, so it cannot win the next cycle too
  one_grant: assert property (@(posedge clk) disable iff (!rst_n)
    !(&res_ready) && ((res_ready & $past(res_ready)) == 2'b00))
    else begin
      $error("arbiter granted both correlators at once, or one twice in a row");
      fail_count++;
    end

  no_x_data: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid |-> !$isunknown(out_data))
    else begin
      $error("unknown bits on out_data while out_valid is high");
      fail_count++;
    end

endmodule

bind corr_bank_top corr_bank_assertions #(
  .LANES (LANES)
) u_assert (
  .clk       (clk),
  .rst_n     (rst_n),
  .in_ready  (in_ready),
  .out_valid (out_valid),
  .out_ready (out_ready),
  .out_data  (out_data),
  .out_src   (out_src),
  .res_ready (res_ready)
);

//--- dv/corr_bank_tb.sv
`timescale 1ns/1ps
`include "corr_patterns.svh"

module corr_bank_tb;

  localparam int LANES    = corr_pkg::DEF_LANES;
  localparam int CORR_LEN = corr_pkg::DEF_CORR_LEN;
  localparam int SW       = corr_pkg::SAMPLE_W;
  localparam int AW       = corr_pkg::ACC_W;
  // beats sent by tests 1 to 6
  localparam int TOTAL_BEATS = 2 + 2 * CORR_LEN + 40 + 40 + 12 + 3 * CORR_LEN;
  localparam int MAX_CYCLES  = 4 * TOTAL_BEATS * (LANES + 4) + 200;
  localparam logic [`CORR_PAT_W-1:0] PATTERNS [2] = `CORR_PATTERNS;
  localparam corr_pkg::sample_t SMAX = corr_pkg::sample_t'(2 ** (SW - 1) - 1);
  localparam corr_pkg::sample_t SMIN = corr_pkg::sample_t'(-(2 ** (SW - 1)));

  typedef logic [LANES*SW-1:0] beat_t;
  typedef logic [LANES*AW-1:0] res_t;

  logic clk, rst_n, in_valid, in_ready, out_valid, out_ready;
  beat_t in_data;
  res_t out_data;
  corr_pkg::corr_id_t out_src;

  // sample history per lane, index 0 is the newest beat
  int hist [LANES][CORR_LEN];
  res_t exp_q0 [$];
  res_t exp_q1 [$];
  int errors, checks, err_mark, cycles, in_cnt, ready_mode, mode_now;
  int out_cnt [2];
  int imp_cnt [2];
  logic imp_on, exp_src;

  corr_bank_top #(
    .LANES    (LANES),
    .CORR_LEN (CORR_LEN)
  ) DUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_data   (in_data),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data),
    .out_src   (out_src)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: run still busy after %0d cycles", MAX_CYCLES);
    $display("Something failed");
    $finish;
  end

  // mode 0 always ready, 1 random, 2 stalled
  always @(posedge clk) begin
    mode_now = ready_mode;
    #2;
    if (mode_now == 1) begin
      out_ready = ($urandom_range(99) < 60);
    end else begin
      out_ready = (mode_now == 0);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // reference model and scoreboard
  //////////////////////////////////////////////////////////////////////

  task automatic check_val(input string name, input res_t got, input res_t want);
    checks++;
    assert (got === want) else begin
      $display("ERR %s: expected %h, got %h", name, want, got);
      errors++;
    end
  endtask

  task automatic model_push(input beat_t d);
    corr_pkg::sample_t s;
    int sum0;
    int sum1;
    res_t e0;
    res_t e1;
    for (int l = 0; l < LANES; l++) begin
      s = d[l*SW +: SW];
      for (int a = CORR_LEN - 1; a > 0; a--) begin
        hist[l][a] = hist[l][a-1];
      end
      hist[l][0] = int'(s);
      sum0 = 0;
      sum1 = 0;
      // set bit adds the sample of that age, clear bit subtracts it
      for (int a = 0; a < CORR_LEN; a++) begin
        sum0 += PATTERNS[0][a] ? hist[l][a] : -hist[l][a];
        sum1 += PATTERNS[1][a] ? hist[l][a] : -hist[l][a];
      end
      e0[l*AW +: AW] = corr_pkg::acc_t'(sum0);
      e1[l*AW +: AW] = corr_pkg::acc_t'(sum1);
    end
    exp_q0.push_back(e0);
    exp_q1.push_back(e1);
    in_cnt++;
  endtask

  task automatic take_result();
    res_t want;
    check_val("out_src", res_t'(out_src), res_t'(exp_src));
    exp_src = ~exp_src;
    out_cnt[out_src]++;
    if ((out_src ? exp_q1.size() : exp_q0.size()) == 0) begin
      $display("result from correlator %0d arrived with no input beat pending", out_src);
      errors++;
    end else begin
      if (out_src) begin
        want = exp_q1.pop_front();
      end else begin
        want = exp_q0.pop_front();
      end
      check_val("out_data", out_data, want);
    end
    // impulse response read straight off the pattern bits
    if (imp_on && imp_cnt[out_src] < CORR_LEN) begin
      want = '0;
      want[AW-1:0] = PATTERNS[out_src][imp_cnt[out_src]] ?
                     corr_pkg::acc_t'(1) : corr_pkg::acc_t'(-1);
      check_val("out_data impulse", out_data, want);
      imp_cnt[out_src]++;
    end
  endtask

  // mid-cycle sampling, transfer happens on the next rising edge
  always @(negedge clk) begin
    if (rst_n && out_valid && out_ready) begin
      take_result();
    end
    if (rst_n && in_valid && in_ready) begin
      model_push(in_data);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus helpers
  //////////////////////////////////////////////////////////////////////

  function automatic beat_t rand_beat();
    beat_t b;
    for (int l = 0; l < LANES; l++) begin
      b[l*SW +: SW] = SW'($urandom);
    end
    return b;
  endfunction

  task automatic send_beat(input beat_t d);
    in_valid = 1'b1;
    in_data  = d;
    @(negedge clk);
    while (!in_ready) begin
      @(negedge clk);
    end
    @(posedge clk);
    #2;
    in_valid = 1'b0;
  endtask

  task automatic drain();
    while (exp_q0.size() != 0 || exp_q1.size() != 0) begin
      @(negedge clk);
    end
    @(posedge clk);
    #2;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      #2;
    end
  endtask

  task automatic check_counts();
    check_val("results from correlator 0", res_t'(out_cnt[0]), res_t'(in_cnt));
    check_val("results from correlator 1", res_t'(out_cnt[1]), res_t'(in_cnt));
  endtask

  task automatic end_test(input int num, input string name);
    int total;
    total = errors + DUT.u_assert.fail_count;
    $display("test %0d %s: %s", num, name, (total == err_mark) ? "passed" : "failed");
    err_mark = total;
  endtask

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin : main
    beat_t b;
    int total;
    void'($urandom(79205));
    rst_n      = 1'b0;
    in_valid   = 1'b0;
    in_data    = '0;
    out_ready  = 1'b1;
    ready_mode = 0;
    imp_on     = 1'b0;
    exp_src    = 1'b0;

    for (int i = 0; i < 7; i++) begin
      @(negedge clk);
      check_val("in_ready", res_t'(in_ready), '0);
      check_val("out_valid", res_t'(out_valid), '0);
    end
    @(posedge clk);
    #2;
    rst_n = 1'b1;
    send_beat(rand_beat());
    send_beat(rand_beat());
    drain();
    end_test(1, "reset state");

    // clear the history, then one impulse on lane 0
    for (int i = 0; i < CORR_LEN; i++) begin
      send_beat('0);
    end
    drain();
    imp_on = 1'b1;
    send_beat(beat_t'(1));
    for (int i = 0; i < CORR_LEN - 1; i++) begin
      send_beat('0);
    end
    drain();
    imp_on = 1'b0;
    end_test(2, "single impulse");

    for (int i = 0; i < 40; i++) begin
      send_beat(rand_beat());
    end
    drain();
    check_counts();
    end_test(3, "random stream");

    ready_mode = 1;
    for (int i = 0; i < 40; i++) begin
      idle($urandom_range(2));
      send_beat(rand_beat());
    end
    drain();
    check_counts();
    end_test(4, "random stalls");

    // both correlators end up holding a result behind a stalled output
    ready_mode = 2;
    send_beat(rand_beat());
    idle(10);
    @(negedge clk);
    check_val("out_valid", res_t'(out_valid), res_t'(1));
    @(posedge clk);
    #2;
    for (int i = 0; i < 11; i++) begin
      ready_mode = 2;
      idle(3);
      ready_mode = 1;
      send_beat(rand_beat());
    end
    drain();
    check_counts();
    end_test(5, "round robin");

    ready_mode = 0;
    for (int i = 0; i < CORR_LEN; i++) begin
      b = {LANES{SMIN}};
      b[0 +: SW]    = PATTERNS[0][CORR_LEN-1-i] ? SMAX : SMIN;
      b[SW +: SW]   = PATTERNS[1][CORR_LEN-1-i] ? SMAX : SMIN;
      b[2*SW +: SW] = PATTERNS[0][CORR_LEN-1-i] ? SMIN : SMAX;
      send_beat(b);
    end
    for (int i = 0; i < CORR_LEN; i++) begin
      send_beat({LANES{SMAX}});
    end
    for (int i = 0; i < CORR_LEN; i++) begin
      send_beat({LANES{SMIN}});
    end
    drain();
    // a late extra result would still be counted here
    idle(LANES + 4);
    check_counts();
    end_test(6, "extreme samples");

    total = errors + DUT.u_assert.fail_count;
    $display("tests: 6, checks: %0d, errors: %0d, assertion failures: %0d",
             checks, errors, DUT.u_assert.fail_count);
    if (total == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

//--- sim.f
+incdir+include
hw/corr_pkg.sv
hw/bit_corr.sv
hw/result_arbiter.sv
hw/corr_bank_top.sv
dv/corr_bank_assertions.sv
dv/corr_bank_tb.sv

//--- Makefile
# Verilator build and run of the correlator bank testbench

TOP := corr_bank_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Everything OK"

clean:
	rm -rf obj_dir
